/* filelist.f */
+incdir+.
msx_upload_pkg.sv
slot_map.sv
block_table.sv
block_copier.sv
config_walker.sv
upload_ram_top.sv
tb_upload_ram.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_upload_ram -f filelist.f -o sim_tb \
   && ./obj_dir/sim_tb \
   || { echo "simulation failed"; exit 1; }

/* tb_mem_models.svh */
`ifndef TB_MEM_MODELS_SVH
`define TB_MEM_MODELS_SVH

int unsigned rd_count = 0;                // Cycles with a DDR3 read pending
int unsigned wr_count = 0;
logic [7:0]  sdram_mem[256];
bit          sdram_written[256];

// DDR3 source, answers a read after 0 to 3 wait cycles
initial begin : ddr3_model
   int unsigned delay;
   delay      = 0;
   ddr3_ready = 1'b0;
   ddr3_dout  = 8'h00;
   forever begin
      @(posedge clk);
      if (ddr3_rd && !ddr3_ready) begin
         rd_count++;
         if (delay == 0) begin
            ddr3_ready <= 1'b1;
            ddr3_dout  <= ddr3_addr[7:0] ^ 8'h5A;
            delay = $urandom_range(3, 0);
         end else begin
            delay--;
         end
      end else begin
         ddr3_ready <= 1'b0;
      end
   end
end

initial begin : sdram_model
   sdram_ready = 1'b0;
   forever begin
      @(posedge clk);
      if (sdram_we) begin
         sdram_mem[sdram_addr[7:0]]     = sdram_din;
         sdram_written[sdram_addr[7:0]] = 1'b1;
         wr_count++;
      end
      sdram_ready <= $urandom_range(3, 0) != 0;   // Stalls about one cycle in four
   end
end

task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] want);
   if (got !== want) begin
      $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, want);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
   end
endtask

`endif

/* tb_upload_ram.sv */
`timescale 1ns/1ns
module tb_upload_ram import msx_upload_pkg::*; ();
   localparam int NCFG        = 4;
   localparam int NBLK        = 16;
   localparam int BLK_BYTES   = 16;               // BLOCK_ADDR_BITS of 4
   localparam int TEST_CYCLES = 20000;
   localparam int NUM_TESTS   = 5;

   logic clk, rst_n, update_request, ddr3_ready, sdram_ready;
   logic update_ack, need_reset, ddr3_rd, ddr3_request, sdram_we, sdram_request;
   logic [1:0]              msx_type;
   logic [7:0]              ddr3_dout, sdram_din;
   logic [DDR3_ADDR_W-1:0]  ddr3_addr;
   logic [SDRAM_ADDR_W-1:0] sdram_addr;
   config_typ_t             cfg_typ[NCFG];
   logic [SLOT_IDX_W-1:0]   cfg_slot[NCFG], cfg_sub_slot[NCFG], cfg_start_block[NCFG];
   logic [BLOCK_ID_W-1:0]   cfg_block_id[NCFG];
   logic [COUNT_W-1:0]      cfg_block_count[NCFG];
   logic                    cfg_mapper[NCFG];
   logic [DDR3_ADDR_W-1:0]  cfg_store_addr[NCFG];
   slot_typ_t               slot_typ[4], subslot_typ[16];
   logic [BLOCK_ID_W-1:0]   blk_id[64];
   logic [SLOT_IDX_W-1:0]   blk_offset[64];
   logic                    blk_init[64];
   logic [COUNT_W-1:0]      mem_block_count[NBLK];
   logic [SDRAM_ADDR_W-1:0] mem_block_offset[NBLK];
   block_typ_t              mem_block_typ[NBLK];

   upload_ram_top #(.MAX_CONFIG(NCFG), .MAX_MEM_BLOCK(NBLK), .BLOCK_ADDR_BITS(4))
      upload_ram_top_inst (.*);

   `include "tb_mem_models.svh"

   initial begin : clock_gen
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin : watchdog
      #(NUM_TESTS * TEST_CYCLES * 40);
      $display("Watchdog expired, the tests did not finish in time");
      $display(">>> FAIL");
      $fatal(1, "watchdog");
   end

   task automatic abort_run(input string why);
      $display("Error at %0t ns: %s", $time, why);
      $display(">>> FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic set_entry(input int i, input config_typ_t typ, input logic [1:0] slot,
                            input logic [1:0] sub, input logic [1:0] start,
                            input logic [3:0] id, input logic [7:0] count,
                            input logic mapper, input logic [27:0] src);
      cfg_typ[i]         <= typ;
      cfg_slot[i]        <= slot;
      cfg_sub_slot[i]    <= sub;
      cfg_start_block[i] <= start;
      cfg_block_id[i]    <= id;
      cfg_block_count[i] <= count;
      cfg_mapper[i]      <= mapper;
      cfg_store_addr[i]  <= src;
   endtask

   // All entries unused, on a rising edge
   task automatic clear_config();
      @(posedge clk);
      for (int i = 0; i < NCFG; i++) set_entry(i, CONFIG_NONE, '0, '0, '0, '0, '0, 1'b0, '0);
   endtask

   task automatic run_update();
      int cyc;
      rd_count = 0;
      wr_count = 0;
      foreach (sdram_written[a]) sdram_written[a] = 1'b0;
      @(posedge clk);
      update_request <= 1'b1;
      cyc = 0;
      while (!update_ack && cyc < 8) begin
         @(posedge clk);
         cyc++;
      end
      if (!update_ack) abort_run("update_ack never rose after the request");
      update_request <= 1'b0;
      expect_equal("need_reset", 32'(need_reset), 1);
      expect_equal("sdram_request", 32'(sdram_request), 1);
      expect_equal("ddr3_request", 32'(ddr3_request), 1);
      cyc = 0;
      while (update_ack && cyc < TEST_CYCLES) begin
         @(posedge clk);
         cyc++;
      end
      if (update_ack) abort_run("update_ack stayed high, the upload never finished");
      expect_equal("need_reset", 32'(need_reset), 0);
      expect_equal("sdram_request", 32'(sdram_request), 0);
      expect_equal("ddr3_request", 32'(ddr3_request), 0);
   endtask

   // ROM bytes are the DDR3 address XOR 5A, RAM bytes are FF
   task automatic check_sdram(input int base, input int n, input bit ram,
                              input logic [DDR3_ADDR_W-1:0] src);
      logic [7:0] want;
      for (int i = 0; i < n; i++) begin
         want = ram ? 8'hFF : (8'(src + DDR3_ADDR_W'(i)) ^ 8'h5A);
         expect_equal($sformatf("written[%0d]", base + i), 32'(sdram_written[base + i]), 1);
         expect_equal($sformatf("sdram[%0d]", base + i), 32'(sdram_mem[base + i]), 32'(want));
      end
   endtask

   task automatic idle_and_clear();
      expect_equal("update_ack", 32'(update_ack), 0);
      expect_equal("need_reset", 32'(need_reset), 0);
      expect_equal("sdram_we", 32'(sdram_we), 0);
      clear_config();
      set_entry(0, CONFIG_RAM, 2'd1, 2'd1, 2'd0, 4'd0, 8'd4, 1'b1, '0);   // Map contents to sweep
      run_update();
      expect_equal("slot_typ[1]", 32'(slot_typ[1]), 32'(SLOT_TYP_MAPPER));
      clear_config();
      run_update();
      for (int b = 0; b < 64; b++)
         expect_equal($sformatf("blk_init[%0d]", b), 32'(blk_init[b]), 0);
      for (int s = 0; s < 4; s++)
         expect_equal($sformatf("slot_typ[%0d]", s), 32'(slot_typ[s]), 32'(SLOT_TYP_EMPTY));
      for (int s = 0; s < 16; s++)
         expect_equal($sformatf("subslot_typ[%0d]", s), 32'(subslot_typ[s]),
                      32'(SLOT_TYP_EMPTY));
      expect_equal("wr_count", wr_count, 0);
   endtask

   task automatic rom_copy();
      clear_config();
      set_entry(0, CONFIG_BIOS, 2'd0, 2'd0, 2'd0, 4'd1, 8'd1, 1'b0, 28'h00310F8);
      run_update();
      check_sdram(0, BLK_BYTES, 1'b0, 28'h00310F8);
      expect_equal("wr_count", wr_count, BLK_BYTES);
      expect_equal("slot_typ[0]", 32'(slot_typ[0]), 32'(SLOT_TYP_ROM));
      expect_equal("blk_init[0]", 32'(blk_init[0]), 1);
      expect_equal("mem_block_typ[1]", 32'(mem_block_typ[1]), 32'(BLOCK_TYP_ROM));
      expect_equal("mem_block_count[1]", 32'(mem_block_count[1]), 1);
      expect_equal("mem_block_offset[1]", 32'(mem_block_offset[1]), 0);
   endtask

   task automatic ram_fill();
      for (int m = 0; m < 2; m++) begin
         clear_config();
         msx_type <= 2'(m);
         set_entry(1, CONFIG_RAM, 2'd3, 2'd2, 2'd0, 4'd2, 8'd2, 1'b0, 28'h0ABCDE0);
         run_update();
         check_sdram(0, 2 * BLK_BYTES, 1'b1, '0);
         expect_equal("wr_count", wr_count, 2 * BLK_BYTES);
         expect_equal("ddr3_rd cycles", rd_count, 0);
         expect_equal("slot_typ[3]", 32'(slot_typ[3]),
                      (m == 0) ? 32'(SLOT_TYP_RAM) : 32'(SLOT_TYP_MSX2_RAM));
         expect_equal("blk_init[57]", 32'(blk_init[57]), 1);   // Slot 3, subslot 2, block 1
         expect_equal("mem_block_typ[2]", 32'(mem_block_typ[2]), 32'(BLOCK_TYP_RAM));
         expect_equal("mem_block_count[2]", 32'(mem_block_count[2]), 2);
      end
   endtask

   // Four blocks from block 1, only three fit the subslot
   task automatic span_and_mapper();
      clear_config();
      set_entry(0, CONFIG_FDC, 2'd1, 2'd3, 2'd1, 4'd3, 8'd4, 1'b1, 28'h0000200);
      run_update();
      check_sdram(0, 4 * BLK_BYTES, 1'b0, 28'h0000200);
      expect_equal("blk_init[28]", 32'(blk_init[28]), 0);
      for (int b = 1; b < 4; b++) begin
         expect_equal($sformatf("blk_init[%0d]", 28 + b), 32'(blk_init[28 + b]), 1);
         expect_equal($sformatf("blk_offset[%0d]", 28 + b), 32'(blk_offset[28 + b]), b - 1);
         expect_equal($sformatf("blk_id[%0d]", 28 + b), 32'(blk_id[28 + b]), 3);
      end
      expect_equal("slot_typ[1]", 32'(slot_typ[1]), 32'(SLOT_TYP_MAPPER));
      expect_equal("subslot_typ[7]", 32'(subslot_typ[7]), 32'(SLOT_TYP_ROM));
      expect_equal("mem_block_typ[3]", 32'(mem_block_typ[3]), 32'(BLOCK_TYP_FDC));
   endtask

   task automatic running_offsets();
      clear_config();
      set_entry(0, CONFIG_BIOS, 2'd0, 2'd1, 2'd0, 4'd4, 8'd2, 1'b0, 28'h01000F0);
      set_entry(2, CONFIG_RAM, 2'd2, 2'd0, 2'd2, 4'd5, 8'd1, 1'b0, 28'h0);
      run_update();
      check_sdram(0, 2 * BLK_BYTES, 1'b0, 28'h01000F0);
      check_sdram(2 * BLK_BYTES, BLK_BYTES, 1'b1, '0);
      expect_equal("wr_count", wr_count, 3 * BLK_BYTES);
      expect_equal("mem_block_offset[4]", 32'(mem_block_offset[4]), 0);
      expect_equal("mem_block_count[4]", 32'(mem_block_count[4]), 2);
      expect_equal("mem_block_offset[5]", 32'(mem_block_offset[5]), 2 * BLK_BYTES);
      expect_equal("mem_block_count[5]", 32'(mem_block_count[5]), 1);
   endtask

   initial begin : main
      void'($urandom(32'h4f7aec73));
      rst_n          = 1'b0;
      update_request = 1'b0;
      msx_type       = 2'd0;
      for (int i = 0; i < NCFG; i++) set_entry(i, CONFIG_NONE, '0, '0, '0, '0, '0, 1'b0, '0);
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      idle_and_clear();
      rom_copy();
      ram_fill();
      span_and_mapper();
      running_offsets();
      $display(">>> PASS");
      $finish;
   end

endmodule

/* upload_ram_top.sv */
`timescale 1ns/1ns
module upload_ram_top import msx_upload_pkg::*; #(
   parameter int MAX_CONFIG      = 16,
   parameter int MAX_MEM_BLOCK   = 16,
   parameter int BLOCK_ADDR_BITS = 14
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    update_request,
   input  logic [1:0]              msx_type,
   input  config_typ_t             cfg_typ[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_slot[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_sub_slot[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_start_block[MAX_CONFIG],
   input  logic [BLOCK_ID_W-1:0]   cfg_block_id[MAX_CONFIG],
   input  logic [COUNT_W-1:0]      cfg_block_count[MAX_CONFIG],
   input  logic                    cfg_mapper[MAX_CONFIG],
   input  logic [DDR3_ADDR_W-1:0]  cfg_store_addr[MAX_CONFIG],
   input  logic                    ddr3_ready,
   input  logic [7:0]              ddr3_dout,
   input  logic                    sdram_ready,
   output logic                    update_ack,
   output logic                    need_reset,
   output logic [DDR3_ADDR_W-1:0]  ddr3_addr,
   output logic                    ddr3_rd,
   output logic                    ddr3_request,
   output logic [SDRAM_ADDR_W-1:0] sdram_addr,
   output logic [7:0]              sdram_din,
   output logic                    sdram_we,
   output logic                    sdram_request,
   output slot_typ_t               slot_typ[4],
   output slot_typ_t               subslot_typ[16],
   output logic [BLOCK_ID_W-1:0]   blk_id[64],
   output logic [SLOT_IDX_W-1:0]   blk_offset[64],
   output logic                    blk_init[64],
   output logic [COUNT_W-1:0]      mem_block_count[MAX_MEM_BLOCK],
   output logic [SDRAM_ADDR_W-1:0] mem_block_offset[MAX_MEM_BLOCK],
   output block_typ_t              mem_block_typ[MAX_MEM_BLOCK]
);
   logic                    busy;
   logic                    clear_start;
   logic                    clear_done;
   logic                    fill_we;
   logic [SLOT_IDX_W-1:0]   fill_slot;
   logic [SLOT_IDX_W-1:0]   fill_subslot;
   logic [SLOT_IDX_W-1:0]   fill_block;
   logic [BLOCK_ID_W-1:0]   fill_block_id;
   logic [COUNT_W-1:0]      fill_count;
   slot_typ_t               fill_slot_typ;
   logic                    fill_mapper;
   logic                    rec_we;
   logic [BLOCK_ID_W-1:0]   rec_block_id;
   logic [COUNT_W-1:0]      rec_count;
   logic [SDRAM_ADDR_W-1:0] rec_offset;
   block_typ_t              rec_typ;
   logic                    copy_start;
   logic                    copy_done;
   logic [DDR3_ADDR_W-1:0]  copy_src;
   logic [COUNT_W-1:0]      copy_count;
   block_typ_t              copy_typ;
   logic                    ptr_clear;

   assign ddr3_request  = busy;
   assign sdram_request = busy;

   config_walker #(.MAX_CONFIG(MAX_CONFIG)) config_walker_inst (.*);

   slot_map slot_map_inst (.*);

   block_table #(.MAX_MEM_BLOCK(MAX_MEM_BLOCK)) block_table_inst (.*);

   block_copier #(.BLOCK_ADDR_BITS(BLOCK_ADDR_BITS)) block_copier_inst (.*);

endmodule

/* config_walker.sv */
`timescale 1ns/1ns
module config_walker import msx_upload_pkg::*; #(
   parameter int MAX_CONFIG = 16
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    update_request,
   input  logic [1:0]              msx_type,
   input  config_typ_t             cfg_typ[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_slot[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_sub_slot[MAX_CONFIG],
   input  logic [SLOT_IDX_W-1:0]   cfg_start_block[MAX_CONFIG],
   input  logic [BLOCK_ID_W-1:0]   cfg_block_id[MAX_CONFIG],
   input  logic [COUNT_W-1:0]      cfg_block_count[MAX_CONFIG],
   input  logic                    cfg_mapper[MAX_CONFIG],
   input  logic [DDR3_ADDR_W-1:0]  cfg_store_addr[MAX_CONFIG],
   input  logic                    clear_done,
   input  logic                    copy_done,
   input  logic [SDRAM_ADDR_W-1:0] sdram_addr,
   output logic                    update_ack,
   output logic                    need_reset,
   output logic                    busy,
   output logic                    clear_start,
   output logic                    fill_we,
   output logic [SLOT_IDX_W-1:0]   fill_slot,
   output logic [SLOT_IDX_W-1:0]   fill_subslot,
   output logic [SLOT_IDX_W-1:0]   fill_block,
   output logic [BLOCK_ID_W-1:0]   fill_block_id,
   output logic [COUNT_W-1:0]      fill_count,
   output slot_typ_t               fill_slot_typ,
   output logic                    fill_mapper,
   output logic                    rec_we,
   output logic [BLOCK_ID_W-1:0]   rec_block_id,
   output logic [COUNT_W-1:0]      rec_count,
   output logic [SDRAM_ADDR_W-1:0] rec_offset,
   output block_typ_t              rec_typ,
   output logic                    copy_start,
   output logic [DDR3_ADDR_W-1:0]  copy_src,
   output logic [COUNT_W-1:0]      copy_count,
   output block_typ_t              copy_typ,
   output logic                    ptr_clear
);
   localparam int CNT_W = (MAX_CONFIG > 1) ? $clog2(MAX_CONFIG) : 1;

   typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_FILL, S_COPY, S_NEXT} state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   config_typ_t      act_typ;
   slot_typ_t        act_slot_typ;
   block_typ_t       act_block_typ;

   assign act_typ = cfg_typ[cnt];

   always_comb begin
      case (act_typ)
         CONFIG_BIOS, CONFIG_FDC: act_slot_typ = SLOT_TYP_ROM;
         default:                 act_slot_typ = (msx_type == 2'd0) ? SLOT_TYP_RAM
                                                                    : SLOT_TYP_MSX2_RAM;
      endcase
      case (act_typ)
         CONFIG_RAM: act_block_typ = BLOCK_TYP_RAM;
         CONFIG_FDC: act_block_typ = BLOCK_TYP_FDC;
         default:    act_block_typ = BLOCK_TYP_ROM;
      endcase
   end

   assign busy       = state != S_IDLE;
   assign update_ack = busy;
   assign need_reset = busy;

   // Entry payload stays put while the strobes fire
   assign fill_slot     = cfg_slot[cnt];
   assign fill_subslot  = cfg_sub_slot[cnt];
   assign fill_block    = cfg_start_block[cnt];
   assign fill_block_id = cfg_block_id[cnt];
   assign fill_count    = cfg_block_count[cnt];
   assign fill_slot_typ = act_slot_typ;
   assign fill_mapper   = cfg_mapper[cnt];
   assign rec_block_id  = cfg_block_id[cnt];
   assign rec_count     = cfg_block_count[cnt];
   assign rec_offset    = sdram_addr;             // Copier has not moved yet
   assign rec_typ       = act_block_typ;
   assign copy_src      = cfg_store_addr[cnt];
   assign copy_count    = cfg_block_count[cnt];
   assign copy_typ      = act_block_typ;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         cnt         <= '0;
         clear_start <= 1'b0;
         ptr_clear   <= 1'b0;
         fill_we     <= 1'b0;
         rec_we      <= 1'b0;
         copy_start  <= 1'b0;
      end else begin
         clear_start <= 1'b0;
         ptr_clear   <= 1'b0;
         fill_we     <= 1'b0;
         rec_we      <= 1'b0;
         copy_start  <= 1'b0;
         case (state)
            S_IDLE: if (update_request) begin
               cnt         <= '0;
               clear_start <= 1'b1;
               ptr_clear   <= 1'b1;
               state       <= S_CLEAR;
            end
            S_CLEAR: if (clear_done) state <= S_FILL;
            S_FILL: begin
               if (act_typ inside {CONFIG_RAM, CONFIG_BIOS, CONFIG_FDC}) begin
                  fill_we    <= 1'b1;
                  rec_we     <= 1'b1;
                  copy_start <= 1'b1;
                  state      <= S_COPY;
               end else begin
                  state <= S_NEXT;                 // Unused entry
               end
            end
            S_COPY: if (copy_done) state <= S_NEXT;
            S_NEXT: begin
               if (cnt == CNT_W'(MAX_CONFIG - 1)) begin
                  state <= S_IDLE;
               end else begin
                  cnt   <= cnt + 1'b1;
                  state <= S_FILL;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

/* block_copier.sv */
`timescale 1ns/1ns
module block_copier import msx_upload_pkg::*; #(
   parameter int BLOCK_ADDR_BITS = 14
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    ptr_clear,
   input  logic                    copy_start,
   input  logic [DDR3_ADDR_W-1:0]  copy_src,
   input  logic [COUNT_W-1:0]      copy_count,
   input  block_typ_t              copy_typ,
   input  logic                    ddr3_ready,
   input  logic [7:0]              ddr3_dout,
   input  logic                    sdram_ready,
   output logic                    copy_done,
   output logic [DDR3_ADDR_W-1:0]  ddr3_addr,
   output logic                    ddr3_rd,
   output logic [SDRAM_ADDR_W-1:0] sdram_addr,
   output logic [7:0]              sdram_din,
   output logic                    sdram_we
);
   localparam int IDX_W = COUNT_W + BLOCK_ADDR_BITS;

   typedef enum logic [1:0] {C_IDLE, C_READ, C_WRITE, C_NEXT} state_t;

   state_t                 state;
   logic [IDX_W-1:0]       idx;
   logic [IDX_W-1:0]       last_idx;
   logic [DDR3_ADDR_W-1:0] src;
   logic [COUNT_W-1:0]     count;
   logic                   fill_ram;          // RAM block, no DDR3 traffic

   assign last_idx  = {count - 1'b1, {BLOCK_ADDR_BITS{1'b1}}};
   assign ddr3_addr = src + DDR3_ADDR_W'(idx);
   assign ddr3_rd   = state == C_READ;        // Held until ready
   assign sdram_we  = (state == C_WRITE) && sdram_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= C_IDLE;
         idx        <= '0;
         copy_done  <= 1'b0;
         sdram_addr <= '0;
      end else begin
         copy_done <= 1'b0;
         if (ptr_clear) begin
            sdram_addr <= '0;
         end else if (sdram_we) begin
            sdram_addr <= sdram_addr + 1'b1;
         end
         case (state)
            C_IDLE: if (copy_start) begin
               idx <= '0;
               if (copy_count == '0) begin
                  copy_done <= 1'b1;           // Nothing to move
               end else if (copy_typ == BLOCK_TYP_RAM) begin
                  state <= C_WRITE;
               end else begin
                  state <= C_READ;
               end
            end
            C_READ:  if (ddr3_ready) state <= C_WRITE;
            C_WRITE: if (sdram_ready) state <= C_NEXT;
            C_NEXT: begin
               if (idx == last_idx) begin
                  copy_done <= 1'b1;
                  state     <= C_IDLE;
               end else begin
                  idx <= idx + 1'b1;
                  if (fill_ram) begin
                     state <= C_WRITE;
                  end else begin
                     state <= C_READ;
                  end
               end
            end
            default: state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (copy_start && state == C_IDLE) begin
         src       <= copy_src;
         count     <= copy_count;
         fill_ram  <= copy_typ == BLOCK_TYP_RAM;
         sdram_din <= RAM_FILL;
      end else if (state == C_READ && ddr3_ready) begin
         sdram_din <= ddr3_dout;                // Latch the DDR3 byte
      end
   end

endmodule

/* block_table.sv */
`timescale 1ns/1ns
module block_table import msx_upload_pkg::*; #(
   parameter int MAX_MEM_BLOCK = 16
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    rec_we,
   input  logic [BLOCK_ID_W-1:0]   rec_block_id,
   input  logic [COUNT_W-1:0]      rec_count,
   input  logic [SDRAM_ADDR_W-1:0] rec_offset,
   input  block_typ_t              rec_typ,
   output logic [COUNT_W-1:0]      mem_block_count[MAX_MEM_BLOCK],
   output logic [SDRAM_ADDR_W-1:0] mem_block_offset[MAX_MEM_BLOCK],
   output block_typ_t              mem_block_typ[MAX_MEM_BLOCK]
);
   logic id_ok;

   assign id_ok = int'(rec_block_id) < MAX_MEM_BLOCK;   // Ids beyond the table are dropped

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MAX_MEM_BLOCK; i++) begin
            mem_block_count[i]  <= '0;
            mem_block_offset[i] <= '0;
            mem_block_typ[i]    <= BLOCK_TYP_RAM;
         end
      end else if (rec_we && id_ok) begin
         mem_block_count[rec_block_id]  <= rec_count;
         mem_block_offset[rec_block_id] <= rec_offset;
         mem_block_typ[rec_block_id]    <= rec_typ;
      end
   end

endmodule

/* slot_map.sv */
`timescale 1ns/1ns
module slot_map import msx_upload_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  clear_start,
   input  logic                  fill_we,
   input  logic [SLOT_IDX_W-1:0] fill_slot,
   input  logic [SLOT_IDX_W-1:0] fill_subslot,
   input  logic [SLOT_IDX_W-1:0] fill_block,
   input  logic [BLOCK_ID_W-1:0] fill_block_id,
   input  logic [COUNT_W-1:0]    fill_count,
   input  slot_typ_t             fill_slot_typ,
   input  logic                  fill_mapper,
   output logic                  clear_done,
   output slot_typ_t             slot_typ[4],
   output slot_typ_t             subslot_typ[16],
   output logic [BLOCK_ID_W-1:0] blk_id[64],
   output logic [SLOT_IDX_W-1:0] blk_offset[64],
   output logic                  blk_init[64]
);
   logic                  clearing;
   logic [5:0]            clr_idx;               // {slot, subslot, block}
   logic [SLOT_IDX_W-1:0] hit_ofs[4];
   logic [3:0]            hit;

   // Blocks of the subslot covered by the current entry
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         hit_ofs[b] = SLOT_IDX_W'(b) - fill_block;
         hit[b]     = (SLOT_IDX_W'(b) >= fill_block) && (COUNT_W'(hit_ofs[b]) < fill_count);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clearing   <= 1'b0;
         clr_idx    <= '0;
         clear_done <= 1'b0;
         for (int i = 0; i < 4; i++) slot_typ[i] <= SLOT_TYP_EMPTY;
         for (int i = 0; i < 16; i++) subslot_typ[i] <= SLOT_TYP_EMPTY;
         for (int i = 0; i < 64; i++) blk_init[i] <= 1'b0;
      end else begin
         clear_done <= 1'b0;
         if (clear_start) begin
            clearing <= 1'b1;
            clr_idx  <= '0;
         end else if (clearing) begin
            blk_init[clr_idx]         <= 1'b0;
            slot_typ[clr_idx[5:4]]    <= SLOT_TYP_EMPTY;
            subslot_typ[clr_idx[5:2]] <= SLOT_TYP_EMPTY;
            clr_idx                   <= clr_idx + 1'b1;
            if (&clr_idx) begin
               clearing   <= 1'b0;
               clear_done <= 1'b1;
            end
         end else if (fill_we) begin
            if (fill_mapper) begin
               slot_typ[fill_slot]                   <= SLOT_TYP_MAPPER;
               subslot_typ[{fill_slot, fill_subslot}] <= fill_slot_typ;
            end else begin
               slot_typ[fill_slot] <= fill_slot_typ;
            end
            for (int b = 0; b < 4; b++) begin
               if (hit[b]) blk_init[{fill_slot, fill_subslot, 2'(b)}] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_we) begin
         for (int b = 0; b < 4; b++) begin
            if (hit[b]) begin
               blk_id[{fill_slot, fill_subslot, 2'(b)}]     <= fill_block_id;
               blk_offset[{fill_slot, fill_subslot, 2'(b)}] <= hit_ofs[b];
            end
         end
      end
   end

endmodule

/* msx_upload_pkg.sv */
package msx_upload_pkg;

   localparam int SLOT_IDX_W   = 2;              // Slot, subslot and block index
   localparam int BLOCK_ID_W   = 4;
   localparam int COUNT_W      = 8;              // Blocks per entry
   localparam int DDR3_ADDR_W  = 28;
   localparam int SDRAM_ADDR_W = 25;

   localparam logic [7:0] RAM_FILL = 8'hFF;     // Erased RAM pattern

   // Config entry kind, NONE marks an unused entry
   typedef enum logic [2:0] {
      CONFIG_NONE = 3'd0,
      CONFIG_RAM  = 3'd1,
      CONFIG_BIOS = 3'd2,
      CONFIG_FDC  = 3'd3
   } config_typ_t;

   typedef enum logic [2:0] {
      SLOT_TYP_EMPTY    = 3'd0,
      SLOT_TYP_ROM      = 3'd1,
      SLOT_TYP_RAM      = 3'd2,
      SLOT_TYP_MSX2_RAM = 3'd3,
      SLOT_TYP_MAPPER   = 3'd4               // Internal memory mapper
   } slot_typ_t;

   typedef enum logic [1:0] {
      BLOCK_TYP_RAM = 2'd0,
      BLOCK_TYP_ROM = 2'd1,
      BLOCK_TYP_FDC = 2'd2
   } block_typ_t;

endpackage
